// ==== hw/axi_rd_pkg.sv ====
`default_nettype none

package axi_rd_pkg;

    // ---------------------------------------------------------------------
    // AXI field types
    // ---------------------------------------------------------------------
    typedef logic [3:0]  axi_id_t;     // Transaction ID, equals slot index
    typedef logic [31:0] axi_addr_t;   // Byte address
    typedef logic [7:0]  axi_len_t;    // Beats minus one
    typedef logic [2:0]  axi_size_t;   // Bytes per beat code
    typedef logic [1:0]  axi_burst_t;  // Burst type
    typedef logic [1:0]  axi_resp_t;   // Larger code is worse
    typedef logic [31:0] axi_data_t;   // One data beat
    typedef logic [3:0]  beat_cnt_t;   // Up to 8 beats per burst

    // Size codes
    localparam axi_size_t AXI_SIZE_1B = 3'b000;
    localparam axi_size_t AXI_SIZE_4B = 3'b010;

    // Burst codes
    localparam axi_burst_t AXI_BURST_FIXED = 2'b00;
    localparam axi_burst_t AXI_BURST_INCR  = 2'b01;
    localparam axi_burst_t AXI_BURST_WRAP  = 2'b10;

    // Response codes, ordered by severity
    localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
    localparam axi_resp_t AXI_RESP_EXOKAY = 2'b01;
    localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;
    localparam axi_resp_t AXI_RESP_DECERR = 2'b11;

    // Address bump for pattern slot 7 on each reuse
    localparam axi_addr_t PATTERN_ADDR_STEP = 32'h0000_0020;

    // ---------------------------------------------------------------------
    // Channel payloads
    // ---------------------------------------------------------------------
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } ar_req_t;                        // 49 bits

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } r_beat_t;                        // 39 bits

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;               // Worst over the burst
        beat_cnt_t beats;              // Includes the last beat
    } rd_result_t;                     // 10 bits

    // Slot lifecycle
    typedef enum logic [1:0] {
        SLOT_FREE    = 2'd0,           // Available for allocation
        SLOT_AR_PEND = 2'd1,           // Waiting for AR handshake
        SLOT_R_PEND  = 2'd2,           // Waiting for last R beat
        SLOT_DONE    = 2'd3            // Burst complete, awaiting retire
    } slot_state_t;

endpackage

`default_nettype wire

// ==== hw/rr_pointer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_pointer #(
    parameter int OST_DEPTH = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [OST_DEPTH-1:0]         req_bits,   // Candidate slots
    input  wire                          advance,    // Consume current pick
    output logic [$clog2(OST_DEPTH)-1:0] ptr
);

    localparam int PTR_W = $clog2(OST_DEPTH);

    logic [PTR_W-1:0] base;                          // Rotation start

    // First set bit at or after base, wrapping past the top slot
    always_comb begin
        logic [PTR_W:0] idx;
        logic           found;
        ptr   = base;                                // Fallback when nothing set
        found = 1'b0;
        for (int k = 0; k < OST_DEPTH; k++) begin
            idx = {1'b0, base} + (PTR_W+1)'(k);
            if (idx >= (PTR_W+1)'(OST_DEPTH)) begin
                idx = idx - (PTR_W+1)'(OST_DEPTH);   // Wrap
            end
            if (!found && req_bits[idx[PTR_W-1:0]]) begin
                ptr   = idx[PTR_W-1:0];
                found = 1'b1;
            end
        end
    end

    // Base moves just past the consumed slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base <= '0;
        end else if (advance) begin
            base <= (ptr == PTR_W'(OST_DEPTH - 1)) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/slot_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_tracker #(
    parameter int OST_DEPTH = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          ar_fire,     // AR handshake this cycle
    input  wire                          last_fire,   // Last R beat accepted
    input  wire  [$clog2(OST_DEPTH)-1:0] last_slot,   // Slot of that last beat
    input  wire  [$clog2(OST_DEPTH)-1:0] alloc_ptr,
    input  wire  [$clog2(OST_DEPTH)-1:0] issue_ptr,
    input  wire  [$clog2(OST_DEPTH)-1:0] retire_ptr,
    output logic [OST_DEPTH-1:0]         free_bits,
    output logic [OST_DEPTH-1:0]         pend_bits,
    output logic [OST_DEPTH-1:0]         done_bits,   // Registered
    output logic                         alloc,
    output logic                         retire,
    output logic                         arvalid
);

    import axi_rd_pkg::*;

    localparam int PTR_W = $clog2(OST_DEPTH);

    slot_state_t state [OST_DEPTH];                   // One FSM per slot

    // ---------------------------------------------------------------------
    // State vectors and events
    // ---------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < OST_DEPTH; i++) begin
            free_bits[i] = (state[i] == SLOT_FREE);
            pend_bits[i] = (state[i] == SLOT_AR_PEND);
        end
    end

    assign alloc   = |free_bits;                      // Fill a slot every cycle one is free
    assign retire  = |done_bits;
    assign arvalid = |pend_bits;                      // Any slot still owes an AR

    // ---------------------------------------------------------------------
    // Slot lifecycle
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                state[i] <= SLOT_FREE;
            end
        end else begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                case (state[i])
                    SLOT_FREE: begin
                        if (alloc && alloc_ptr == PTR_W'(i)) begin
                            state[i] <= SLOT_AR_PEND;
                        end
                    end
                    SLOT_AR_PEND: begin
                        if (ar_fire && issue_ptr == PTR_W'(i)) begin
                            state[i] <= SLOT_R_PEND;   // Request is out
                        end
                    end
                    SLOT_R_PEND: begin
                        if (last_fire && last_slot == PTR_W'(i)) begin
                            state[i] <= SLOT_DONE;
                        end
                    end
                    SLOT_DONE: begin
                        if (retire && retire_ptr == PTR_W'(i)) begin
                            state[i] <= SLOT_FREE;     // Index reusable
                        end
                    end
                    default: state[i] <= SLOT_FREE;
                endcase
            end
        end
    end

    // Done vector lags the state by a cycle
    // Bit of the slot being retired is dropped so it is not picked twice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_bits <= '0;
        end else begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                done_bits[i] <= (state[i] == SLOT_DONE) &&
                                !(retire && retire_ptr == PTR_W'(i));
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ar_pattern_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module ar_pattern_table #(
    parameter int OST_DEPTH = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          alloc,       // Write entry this cycle
    input  wire  [$clog2(OST_DEPTH)-1:0] alloc_ptr,
    input  wire  [$clog2(OST_DEPTH)-1:0] issue_ptr,
    output axi_rd_pkg::ar_req_t          ar
);

    import axi_rd_pkg::*;

    ar_req_t    entry [OST_DEPTH];                    // AR payload per slot
    ar_req_t    fill;                                 // Entry for the allocated slot
    logic [2:0] pat_sel;                              // Low index bits pick the pattern

    assign pat_sel = 3'(alloc_ptr);

    // ---------------------------------------------------------------------
    // Pattern lookup
    // ---------------------------------------------------------------------
    always_comb begin
        fill.id   = axi_id_t'(alloc_ptr);             // ID is the slot index
        fill.size = AXI_SIZE_4B;
        case (pat_sel)
            3'd0: begin
                fill.addr  = 32'h0000_0000;
                fill.len   = 8'd3;
                fill.burst = AXI_BURST_INCR;
            end
            3'd1: begin
                fill.addr  = 32'h0000_0010;
                fill.len   = 8'd7;
                fill.burst = AXI_BURST_INCR;
            end
            3'd2: begin
                fill.addr  = 32'h0000_0020;
                fill.len   = 8'd7;
                fill.burst = AXI_BURST_INCR;
            end
            3'd3: begin
                fill.addr  = 32'h0000_0030;
                fill.len   = 8'd3;
                fill.burst = AXI_BURST_FIXED;
            end
            3'd4: begin
                fill.addr  = 32'h0000_0034;
                fill.len   = 8'd3;
                fill.burst = AXI_BURST_WRAP;
            end
            3'd5: begin
                fill.addr  = 32'h0000_0038;
                fill.len   = 8'd7;
                fill.burst = AXI_BURST_WRAP;
            end
            3'd6: begin
                fill.addr  = 32'h0000_0040;
                fill.len   = 8'd7;
                fill.burst = AXI_BURST_FIXED;
            end
            default: begin                            // Pattern 7 walks upward
                fill.addr  = entry[alloc_ptr].addr + PATTERN_ADDR_STEP;
                fill.len   = 8'd3;
                fill.burst = AXI_BURST_INCR;
            end
        endcase
    end

    // Reset value seeds the walking address of pattern 7
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < OST_DEPTH; i++) begin
                entry[i] <= '{id: '0, addr: '0, len: '0,
                              size: AXI_SIZE_1B, burst: AXI_BURST_INCR};
            end
        end else if (alloc) begin
            entry[alloc_ptr] <= fill;
        end
    end

    assign ar = entry[issue_ptr];                     // Held while the pointer holds

endmodule

`default_nettype wire

// ==== hw/r_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module r_collector #(
    parameter int OST_DEPTH = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          alloc,
    input  wire  [$clog2(OST_DEPTH)-1:0] alloc_ptr,
    input  wire  axi_rd_pkg::r_beat_t    r,
    input  wire                          rvalid,
    output logic                         rready,
    output logic                         last_fire,
    output logic [$clog2(OST_DEPTH)-1:0] last_slot,
    output axi_rd_pkg::rd_result_t       result,
    output logic                         result_valid // One-cycle strobe
);

    import axi_rd_pkg::*;

    localparam int PTR_W = $clog2(OST_DEPTH);

    beat_cnt_t        beat_cnt [OST_DEPTH];           // Beats seen so far
    axi_resp_t        worst    [OST_DEPTH];           // Worst resp so far
    logic             beat_fire;
    logic [PTR_W-1:0] beat_slot;
    beat_cnt_t        cnt_upd;
    axi_resp_t        resp_upd;

    assign beat_fire = rvalid & rready;
    assign beat_slot = r.id[PTR_W-1:0];               // ID maps straight to slot
    assign last_fire = beat_fire & r.last;
    assign last_slot = beat_slot;

    // Values after this beat, shared by the table and the result
    assign cnt_upd  = beat_cnt[beat_slot] + 1'b1;
    assign resp_upd = (r.resp > worst[beat_slot]) ? r.resp : worst[beat_slot];

    // ---------------------------------------------------------------------
    // Per-slot accumulation
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (alloc) begin
            beat_cnt[alloc_ptr] <= '0;                // Fresh burst
            worst[alloc_ptr]    <= AXI_RESP_OKAY;
        end
        if (beat_fire) begin
            beat_cnt[beat_slot] <= cnt_upd;
            worst[beat_slot]    <= resp_upd;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (last_fire) begin
            result <= '{id: r.id, resp: resp_upd, beats: cnt_upd};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rready       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            rready       <= 1'b1;                     // Always accept data
            result_valid <= last_fire;
        end
    end

endmodule

`default_nettype wire

// ==== hw/req_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_counter #(
    parameter int REQ_TOTAL = 32
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  result_valid,                        // One per completed burst
    output logic finish
);

    localparam int CNT_W = $clog2(REQ_TOTAL + 1);

    logic [CNT_W-1:0] done_cnt;

    // Stops at the target so finish holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_cnt <= '0;
        end else if (result_valid && done_cnt != CNT_W'(REQ_TOTAL)) begin
            done_cnt <= done_cnt + 1'b1;
        end
    end

    assign finish = (done_cnt == CNT_W'(REQ_TOTAL));

endmodule

`default_nettype wire

// ==== hw/axi_rd_traffic_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_traffic_gen #(
    parameter int OST_DEPTH = 8,                      // Outstanding slots
    parameter int REQ_TOTAL = 32                      // Bursts until finish
) (
    input  wire                     clk,
    input  wire                     rst_n,
    // AR channel
    output axi_rd_pkg::ar_req_t     ar,
    output logic                    arvalid,
    input  wire                     arready,
    // R channel
    input  wire axi_rd_pkg::r_beat_t r,
    input  wire                     rvalid,
    output logic                    rready,
    // Completion report
    output axi_rd_pkg::rd_result_t  result,
    output logic                    result_valid,
    output logic                    finish
);

    localparam int PTR_W = $clog2(OST_DEPTH);

    logic [OST_DEPTH-1:0] free_bits;
    logic [OST_DEPTH-1:0] pend_bits;
    logic [OST_DEPTH-1:0] done_bits;
    logic                 alloc;
    logic                 retire;
    logic                 last_fire;
    logic [PTR_W-1:0]     alloc_ptr;
    logic [PTR_W-1:0]     issue_ptr;
    logic [PTR_W-1:0]     retire_ptr;
    logic [PTR_W-1:0]     last_slot;
    wire                  ar_fire = arvalid & arready;

    // ---------------------------------------------------------------------
    // Slot control
    // ---------------------------------------------------------------------
    slot_tracker #(.OST_DEPTH(OST_DEPTH)) slot_tracker_i (
        .clk, .rst_n, .ar_fire, .last_fire, .last_slot,
        .alloc_ptr, .issue_ptr, .retire_ptr,
        .free_bits, .pend_bits, .done_bits, .alloc, .retire, .arvalid
    );

    rr_pointer #(.OST_DEPTH(OST_DEPTH)) alloc_rr_i (  // Next free slot
        .clk, .rst_n, .req_bits(free_bits), .advance(alloc), .ptr(alloc_ptr)
    );

    rr_pointer #(.OST_DEPTH(OST_DEPTH)) issue_rr_i (  // Next AR to send
        .clk, .rst_n, .req_bits(pend_bits), .advance(ar_fire), .ptr(issue_ptr)
    );

    rr_pointer #(.OST_DEPTH(OST_DEPTH)) retire_rr_i ( // Next slot to free
        .clk, .rst_n, .req_bits(done_bits), .advance(retire), .ptr(retire_ptr)
    );

    // ---------------------------------------------------------------------
    // Datapath
    // ---------------------------------------------------------------------
    ar_pattern_table #(.OST_DEPTH(OST_DEPTH)) ar_table_i (
        .clk, .rst_n, .alloc, .alloc_ptr, .issue_ptr, .ar
    );

    r_collector #(.OST_DEPTH(OST_DEPTH)) r_collector_i (
        .clk, .rst_n, .alloc, .alloc_ptr, .r, .rvalid,
        .rready, .last_fire, .last_slot, .result, .result_valid
    );

    req_counter #(.REQ_TOTAL(REQ_TOTAL)) req_counter_i (
        .clk, .rst_n, .result_valid, .finish
    );

endmodule

`default_nettype wire

// ==== testbench/axi_rd_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_slave_model (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire axi_rd_pkg::ar_req_t ar,
    input  wire                      arvalid,
    output logic                     arready = 1'b0,
    output axi_rd_pkg::r_beat_t      r = '0,
    output logic                     rvalid = 1'b0,
    input  wire                      rready,
    input  wire                      hold,    // Stop accepting AR
    input  wire                      mute,    // Stop returning R
    input  wire                      gaps     // Random arready gaps
);

    import axi_rd_pkg::*;

    ar_req_t   pend_q [$];                    // Accepted, not yet answered
    axi_resp_t resp_q [$];                    // Response codes, one per beat
    axi_len_t  beat_idx = '0;

    task load_resp(input axi_resp_t code);
        resp_q.push_back(code);
    endtask

    // Handshakes complete on the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (arvalid && arready) pend_q.push_back(ar);
            if (rvalid && rready) begin
                if (resp_q.size() > 0) void'(resp_q.pop_front());
                if (r.last) begin
                    void'(pend_q.pop_front());
                    beat_idx = '0;
                end else begin
                    beat_idx = beat_idx + 1'b1;
                end
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        arready = rst_n && !hold && (!gaps || ($urandom % 4) != 0);
        if (rst_n && !mute && pend_q.size() > 0) begin
            rvalid = 1'b1;
            r.id   = pend_q[0].id;
            r.data = pend_q[0].addr + 32'(beat_idx);
            r.resp = (resp_q.size() > 0) ? resp_q[0] : AXI_RESP_OKAY;
            r.last = (beat_idx == pend_q[0].len);
        end else begin
            rvalid = 1'b0;
            r      = '0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_axi_rd_traffic_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_traffic_gen;

    import axi_rd_pkg::*;

    localparam int CLK_NS        = 10;
    localparam int BEATS_PLANNED = 64 * 8;    // Upper bound on beats in the run
    localparam int WATCHDOG_NS   = 40 * BEATS_PLANNED * CLK_NS;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    ar_req_t    ar;
    logic       arvalid, arready, rvalid, rready, result_valid, finish;
    r_beat_t    r;
    rd_result_t result;
    logic       hold = 1'b1;
    logic       mute = 1'b1;
    logic       gaps = 1'b0;

    // Scoreboard
    ar_req_t    ar_log [$];
    rd_result_t exp_q [$];
    axi_resp_t  seen_worst [16];
    axi_len_t   issued_len [16];
    int         id7_uses = 0;
    int         res_count = 0;
    int         checks = 0;
    int         errors = 0;

    axi_rd_traffic_gen #(.OST_DEPTH(8), .REQ_TOTAL(32)) dut_i (
        .clk, .rst_n, .ar, .arvalid, .arready, .r, .rvalid, .rready,
        .result, .result_valid, .finish
    );

    axi_rd_slave_model slave_i (
        .clk, .rst_n, .ar, .arvalid, .arready, .r, .rvalid, .rready,
        .hold, .mute, .gaps
    );

    initial begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Expected values and compare tasks
    // ------------------------------------------------------------------
    function automatic ar_req_t pattern_req(input axi_id_t id, input int n7);
        ar_req_t e;
        case (id[2:0])
            3'd0: e = '{id: id, addr: 32'h00, len: 8'd3, size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
            3'd1: e = '{id: id, addr: 32'h10, len: 8'd7, size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
            3'd2: e = '{id: id, addr: 32'h20, len: 8'd7, size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
            3'd3: e = '{id: id, addr: 32'h30, len: 8'd3, size: AXI_SIZE_4B, burst: AXI_BURST_FIXED};
            3'd4: e = '{id: id, addr: 32'h34, len: 8'd3, size: AXI_SIZE_4B, burst: AXI_BURST_WRAP};
            3'd5: e = '{id: id, addr: 32'h38, len: 8'd7, size: AXI_SIZE_4B, burst: AXI_BURST_WRAP};
            3'd6: e = '{id: id, addr: 32'h40, len: 8'd7, size: AXI_SIZE_4B, burst: AXI_BURST_FIXED};
            default: e = '{id: id, addr: 32'(32'h20 * n7), len: 8'd3,
                           size: AXI_SIZE_4B, burst: AXI_BURST_INCR};   // Walks by 0x20
        endcase
        return e;
    endfunction

    task automatic check_ar(input string name, input ar_req_t got, input ar_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_result(input string name, input rd_result_t got,
                                input rd_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // Bus monitor, values sampled just before each rising edge
    // ------------------------------------------------------------------
    always @(posedge clk) begin : monitor
        axi_resp_t worst;
        if (rst_n) begin
            if (result_valid) begin
                res_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Result strobe seen with no completed burst");
                end else begin
                    check_result("result", result, exp_q.pop_front());
                end
            end
            if (arvalid && arready) begin
                if (ar.id == 4'd7) id7_uses++;
                check_ar("ar", ar, pattern_req(ar.id, id7_uses));
                ar_log.push_back(ar);
                issued_len[ar.id] = ar.len;
            end
            if (rvalid && rready) begin
                worst = (r.resp > seen_worst[r.id]) ? r.resp : seen_worst[r.id];
                seen_worst[r.id] = worst;
                if (r.last) begin
                    exp_q.push_back('{id: r.id, resp: worst,
                                      beats: 4'(issued_len[r.id] + 1)});
                    seen_worst[r.id] = AXI_RESP_OKAY;
                end
            end
        end
    end

    task automatic wait_results(input int target, input int limit);
        int n;
        n = 0;
        while (res_count < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (res_count < target) begin
            errors++;
            $display("Timed out waiting for %0d results, saw %0d", target, res_count);
        end
    endtask

    task automatic load_random_resps(input int count);
        for (int i = 0; i < count; i++) slave_i.load_resp(axi_resp_t'($urandom % 4));
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%-12s %s", name, (errors == err_before) ? "ok" : "has errors");
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (2) begin
            @(negedge clk);
            check_bit("arvalid", arvalid, 1'b0);
            check_bit("result_valid", result_valid, 1'b0);
            check_bit("finish", finish, 1'b0);
            check_bit("rready", rready, 1'b0);
        end
        rst_n = 1'b1;
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("finish", finish, 1'b0);
        @(negedge clk);
        check_bit("rready", rready, 1'b1);     // Up from the first edge out of reset
        report_test("reset", e0);
    endtask

    task automatic test_outstanding();
        int e0;
        int n;
        e0 = errors;
        repeat (10) @(negedge clk);
        check_bit("arvalid", arvalid, 1'b1);
        check_ar("ar_held", ar, pattern_req(axi_id_t'(0), 1));   // Slot 0 waits at the head
        hold = 1'b0;                           // Accept, but return no data
        n = 0;
        while (ar_log.size() < 8 && n < 100) begin
            @(negedge clk);
            n++;
        end
        repeat (20) begin
            @(negedge clk);
            check_bit("arvalid", arvalid, 1'b0);
        end
        check_bit("eight_accepted", ar_log.size() == 8, 1'b1);
        report_test("outstanding", e0);
    endtask

    task automatic test_pattern();
        int e0;
        e0 = errors;
        for (int i = 0; i < 8 && i < ar_log.size(); i++) begin
            check_ar("first_ar", ar_log[i], pattern_req(axi_id_t'(i), 1));
        end
        report_test("pattern", e0);
    endtask

    task automatic test_completion();
        int e0;
        e0 = errors;
        load_random_resps(48);                 // Beats of the first eight bursts
        mute = 1'b0;
        wait_results(8, 400);
        report_test("completion", e0);
    endtask

    task automatic test_recycle();
        int e0;
        int n;
        e0 = errors;
        gaps = 1'b1;
        load_random_resps(600);
        wait_results(31, 3000);
        check_bit("finish_at_31", finish, 1'b0);
        wait_results(32, 300);
        check_bit("finish_at_32", finish, 1'b1);
        n = 0;
        while (res_count < 48 && n < 3000) begin
            @(negedge clk);
            check_bit("finish_held", finish, 1'b1);
            n++;
        end
        check_bit("traffic_after_finish", res_count >= 48, 1'b1);
        check_bit("id7_reused", id7_uses >= 4, 1'b1);
        report_test("recycle", e0);
    endtask

    initial begin
        void'($urandom(32'hc3ea));
        for (int i = 0; i < 16; i++) begin
            seen_worst[i] = AXI_RESP_OKAY;
            issued_len[i] = '0;
        end
        test_reset();
        test_outstanding();
        test_pattern();
        test_completion();
        test_recycle();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/axi_rd_pkg.sv
hw/rr_pointer.sv
hw/slot_tracker.sv
hw/ar_pattern_table.sv
hw/r_collector.sv
hw/req_counter.sv
hw/axi_rd_traffic_gen.sv
testbench/axi_rd_slave_model.sv
testbench/tb_axi_rd_traffic_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, status follows the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_axi_rd_traffic_gen -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep "Testbench passed" > /dev/null \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }
